// File: filelist.f
src/macc_pkg.sv
src/apb_macc_regs.sv
src/operand_fifo.sv
src/macc_pipeline.sv
src/macc_top.sv
verification/tb_macc.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the MAC engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_macc \
	-f filelist.f -o sim_macc > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_macc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "tests failed" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation reported no failure"
exit 0

// File: verification/tb_macc.sv
// Directed APB tests of macc_top; expects run, clear and all results to settle before each readback
`timescale 1ns/10ps

module tb_macc;

	// About 1300 two-cycle transfers plus status polling fit well inside this limit
	localparam int max_cycles = 20000;
	localparam logic signed [63:0] model_max = 64'sh0000_007F_FFFF_FFFF;
	localparam logic signed [63:0] model_min = -64'sh0000_0080_0000_0000;

	logic        clk;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	int value_errors;
	int other_errors;
	int cycles;
	logic [31:0] lcg_state;

	// Reference accumulator and sticky flag
	logic signed [63:0] model_acc;
	logic               model_ovf;

	macc_top i_dut (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Operand word from the upper halves of two draws with b high and a low
	function automatic logic [31:0] random_pair();
		logic [31:0] r1;
		logic [31:0] r2;
		r1 = lcg_next();
		r2 = lcg_next();
		return {r2[31:16], r1[31:16]};
	endfunction

	// Accumulation rule at 64 bits with clamping to the 40-bit range
	task automatic model_apply(input macc_pkg::macc_op_e op, input logic signed [15:0] a,
			input logic signed [15:0] b);
		logic signed [63:0] a_ext;
		logic signed [63:0] b_ext;
		logic signed [63:0] sum;
		a_ext = a;
		b_ext = b;
		if (op == macc_pkg::op_mac && model_ovf) begin
			return;
		end
		case (op)
			macc_pkg::op_mac: sum = model_acc + a_ext * b_ext;
			macc_pkg::op_load: sum = a_ext * b_ext;
			default: sum = 64'sd0;
		endcase
		model_ovf = 1'b0;
		if (sum > model_max) begin
			model_acc = model_max;
			model_ovf = 1'b1;
		end else if (sum < model_min) begin
			model_acc = model_min;
			model_ovf = 1'b1;
		end else begin
			model_acc = sum;
		end
	endtask

	// Two-cycle transfer entered and left on a falling edge
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		// Mid access phase and clear of both edges
		#1;
		err = pslverr;
		if (pready !== 1'b1) begin
			other_errors++;
			$display("At %0t pready was low in a write access", $time);
		end
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		#1;
		data = prdata;
		err = pslverr;
		if (pready !== 1'b1) begin
			other_errors++;
			$display("At %0t pready was low in a read access", $time);
		end
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
		logic err;
		apb_write(addr, data, err);
		if (err) begin
			other_errors++;
			$display("At %0t a write to 0x%h was rejected with pslverr", $time, addr);
		end
	endtask

	task automatic push_mac(input logic [31:0] word);
		write_ok(macc_pkg::addr_operand, word);
		model_apply(macc_pkg::op_mac, word[15:0], word[31:16]);
	endtask

	task automatic check_reg(input logic [7:0] addr, input string name, input logic [31:0] expected);
		logic [31:0] got;
		logic err;
		apb_read(addr, got, err);
		if (err) begin
			other_errors++;
			$display("At %0t a read of %s returned pslverr", $time, name);
		end
		if (got !== expected) begin
			value_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	// Poll until FIFO and pipeline are both drained
	task automatic wait_idle();
		logic [31:0] st;
		logic err;
		do begin
			apb_read(macc_pkg::addr_status, st, err);
			if (err) begin
				other_errors++;
				$display("At %0t a status read returned pslverr while polling", $time);
			end
		end while (st[macc_pkg::status_busy_bit]);
	endtask

	// Idle status is empty plus the overflow flag
	task automatic check_acc();
		check_reg(macc_pkg::addr_acc_lo, "acc_lo", model_acc[31:0]);
		check_reg(macc_pkg::addr_acc_hi, "acc_hi", 32'(model_acc >>> 32));
		check_reg(macc_pkg::addr_status, "status", 32'h10 | (32'(model_ovf) << 7));
	endtask

	task automatic test_reset_decode();
		logic [31:0] data;
		logic err;
		$display("Test 1: reset and decode");
		check_reg(macc_pkg::addr_status, "status", 32'h0000_0010);
		check_reg(macc_pkg::addr_acc_lo, "acc_lo", 32'h0);
		check_reg(macc_pkg::addr_acc_hi, "acc_hi", 32'h0);
		check_reg(macc_pkg::addr_ctrl, "ctrl", 32'h0);
		apb_read(8'h20, data, err);
		if (!err) begin
			other_errors++;
			$display("At %0t a read of unmapped 0x20 got no pslverr", $time);
		end
		apb_write(8'h20, 32'hFFFF_FFFF, err);
		if (!err) begin
			other_errors++;
			$display("At %0t a write to unmapped 0x20 got no pslverr", $time);
		end
	endtask

	task automatic test_streaming();
		$display("Test 2: random streaming");
		write_ok(macc_pkg::addr_ctrl, 32'h1);
		for (int i = 0; i < 40; i++) begin
			push_mac(random_pair());
		end
		wait_idle();
		check_acc();
	endtask

	task automatic test_load_clear();
		logic [31:0] word;
		$display("Test 3: load and clear");
		word = random_pair();
		write_ok(macc_pkg::addr_load, word);
		model_apply(macc_pkg::op_load, word[15:0], word[31:16]);
		for (int i = 0; i < 5; i++) begin
			push_mac(random_pair());
		end
		wait_idle();
		check_acc();
		// Clear while keeping run set
		write_ok(macc_pkg::addr_ctrl, 32'h3);
		model_apply(macc_pkg::op_clear, 16'sd0, 16'sd0);
		wait_idle();
		check_acc();
	endtask

	task automatic test_backpressure();
		logic err;
		$display("Test 4: back-pressure");
		write_ok(macc_pkg::addr_ctrl, 32'h0);
		for (int i = 0; i < 8; i++) begin
			push_mac(random_pair());
		end
		// Count 8 with full and busy set
		check_reg(macc_pkg::addr_status, "status", 32'd8 | (32'h1 << 5) | (32'h1 << 6));
		apb_write(macc_pkg::addr_operand, random_pair(), err);
		if (!err) begin
			other_errors++;
			$display("At %0t a write into a full FIFO got no pslverr", $time);
		end
		write_ok(macc_pkg::addr_ctrl, 32'h1);
		wait_idle();
		check_acc();
	endtask

	task automatic test_saturation();
		$display("Test 5: saturation");
		write_ok(macc_pkg::addr_ctrl, 32'h3);
		model_apply(macc_pkg::op_clear, 16'sd0, 16'sd0);
		// Each product is 2^30 so 512 of them reach 2^39
		for (int i = 0; i < 513; i++) begin
			push_mac(32'h8000_8000);
		end
		wait_idle();
		check_acc();
		push_mac(32'h7FFF_8000);
		wait_idle();
		check_acc();
		write_ok(macc_pkg::addr_ctrl, 32'h3);
		model_apply(macc_pkg::op_clear, 16'sd0, 16'sd0);
		for (int i = 0; i < 520; i++) begin
			push_mac(32'h7FFF_8000);
		end
		wait_idle();
		check_acc();
		// Load of 3 times -5
		write_ok(macc_pkg::addr_load, 32'hFFFB_0003);
		model_apply(macc_pkg::op_load, 16'sd3, -16'sd5);
		wait_idle();
		check_acc();
	endtask

	initial begin
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 32'h0;
		value_errors = 0;
		other_errors = 0;
		cycles = 0;
		lcg_state = 32'h7492_504a;
		model_acc = 64'sd0;
		model_ovf = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_reset_decode();
		test_streaming();
		test_load_clear();
		test_backpressure();
		test_saturation();
		$display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: src/macc_top.sv
// Top level of the APB MAC engine; APB slave without wait states, strobes or protection
`timescale 1ns/10ps

module macc_top (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             psel,
	input  logic                             penable,
	input  logic                             pwrite,
	input  logic [macc_pkg::addr_width-1:0]  paddr,
	input  logic [macc_pkg::data_width-1:0]  pwdata,
	output logic [macc_pkg::data_width-1:0]  prdata,
	output logic                             pready,
	output logic                             pslverr
);

	// Register block to FIFO
	logic                                     push;
	macc_pkg::macc_op_e                       push_op;
	logic signed [macc_pkg::sample_width-1:0] push_a;
	logic signed [macc_pkg::sample_width-1:0] push_b;
	logic                                     full;
	logic                                     empty;
	logic [macc_pkg::count_width-1:0]         count;

	// FIFO to pipeline
	logic                                     pop;
	macc_pkg::macc_op_e                       pop_op;
	logic signed [macc_pkg::sample_width-1:0] pop_a;
	logic signed [macc_pkg::sample_width-1:0] pop_b;

	// Pipeline back to register block
	logic                                     run;
	logic signed [macc_pkg::acc_width-1:0]    acc;
	logic                                     overflow;
	logic                                     pipe_busy;

	// Producer
	apb_macc_regs i_regs (
		.clk       (clk),
		.rst       (rst),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.push      (push),
		.push_op   (push_op),
		.push_a    (push_a),
		.push_b    (push_b),
		.run       (run),
		.full      (full),
		.empty     (empty),
		.count     (count),
		.acc       (acc),
		.overflow  (overflow),
		.pipe_busy (pipe_busy)
	);

	// Buffer
	operand_fifo i_fifo (
		.clk     (clk),
		.rst     (rst),
		.push    (push),
		.push_op (push_op),
		.push_a  (push_a),
		.push_b  (push_b),
		.pop     (pop),
		.pop_op  (pop_op),
		.pop_a   (pop_a),
		.pop_b   (pop_b),
		.full    (full),
		.empty   (empty),
		.count   (count)
	);

	// Consumer
	macc_pipeline i_pipe (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.empty     (empty),
		.pop_op    (pop_op),
		.pop_a     (pop_a),
		.pop_b     (pop_b),
		.pop       (pop),
		.acc       (acc),
		.overflow  (overflow),
		.pipe_busy (pipe_busy)
	);

endmodule

// File: src/macc_pipeline.sv
// Three-stage signed MAC with saturating 40-bit accumulator; pops the FIFO whenever run is set
`timescale 1ns/10ps

module macc_pipeline (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic                                     run,
	input  logic                                     empty,
	input  macc_pkg::macc_op_e                       pop_op,
	input  logic signed [macc_pkg::sample_width-1:0] pop_a,
	input  logic signed [macc_pkg::sample_width-1:0] pop_b,
	output logic                                     pop,
	output logic signed [macc_pkg::acc_width-1:0]    acc,
	output logic                                     overflow,
	output logic                                     pipe_busy
);

	// Stage 1, registered operands
	logic                                     s1_valid;
	macc_pkg::macc_op_e                       s1_op;
	logic signed [macc_pkg::sample_width-1:0] a_reg;
	logic signed [macc_pkg::sample_width-1:0] b_reg;

	// Stage 2, registered product
	logic                                     s2_valid;
	macc_pkg::macc_op_e                       s2_op;
	logic signed [macc_pkg::prod_width-1:0]   mult_reg;

	// Stage 3 guard arithmetic, one bit wider than acc
	logic signed [macc_pkg::acc_width:0] acc_ext;
	logic signed [macc_pkg::acc_width:0] prod_ext;
	logic signed [macc_pkg::acc_width:0] sum;
	logic                                out_of_range;

	// Take one entry per cycle while running
	assign pop = run & ~empty;

	// Valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= pop;
			s2_valid <= s1_valid;
		end
	end

	// Payload stages
	always_ff @(posedge clk) begin
		s1_op <= pop_op;
		a_reg <= pop_a;
		b_reg <= pop_b;
		s2_op <= s1_op;
		// Full 32-bit signed product
		mult_reg <= a_reg * b_reg;
	end

	// Next accumulator value before saturation
	always_comb begin
		acc_ext = {acc[macc_pkg::acc_width-1], acc};
		prod_ext = mult_reg;
		case (s2_op)
			macc_pkg::op_mac: begin
				// Saturated value is held until a load or clear
				if (overflow) begin
					sum = acc_ext;
				end else begin
					sum = acc_ext + prod_ext;
				end
			end
			macc_pkg::op_load: sum = prod_ext;
			macc_pkg::op_clear: sum = '0;
			default: sum = acc_ext;
		endcase
	end

	// Guard bit disagreeing with the sign means the 40-bit range was left
	assign out_of_range = sum[macc_pkg::acc_width] ^ sum[macc_pkg::acc_width-1];

	// Accumulate stage
	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
			overflow <= 1'b0;
		end else if (s2_valid) begin
			if (out_of_range) begin
				// Clamp to the nearest limit
				acc <= sum[macc_pkg::acc_width] ? macc_pkg::acc_min : macc_pkg::acc_max;
			end else begin
				acc <= sum[macc_pkg::acc_width-1:0];
			end
			// Sticky across macs, dropped by load and clear
			overflow <= ((s2_op == macc_pkg::op_mac) & overflow) | out_of_range;
		end
	end

	// Entries still on their way to acc
	assign pipe_busy = s1_valid | s2_valid;

endmodule

// File: src/operand_fifo.sv
// Synchronous FIFO; the caller must not push when full nor pop when empty, contents are not reset
`timescale 1ns/10ps

module operand_fifo (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic                                     push,
	input  macc_pkg::macc_op_e                       push_op,
	input  logic signed [macc_pkg::sample_width-1:0] push_a,
	input  logic signed [macc_pkg::sample_width-1:0] push_b,
	input  logic                                     pop,
	output macc_pkg::macc_op_e                       pop_op,
	output logic signed [macc_pkg::sample_width-1:0] pop_a,
	output logic signed [macc_pkg::sample_width-1:0] pop_b,
	output logic                                     full,
	output logic                                     empty,
	output logic [macc_pkg::count_width-1:0]         count
);

	// Storage, one slot per entry
	macc_pkg::macc_op_e                       op_mem [macc_pkg::fifo_depth];
	logic signed [macc_pkg::sample_width-1:0] a_mem [macc_pkg::fifo_depth];
	logic signed [macc_pkg::sample_width-1:0] b_mem [macc_pkg::fifo_depth];

	// Pointers wrap naturally at fifo_depth
	logic [macc_pkg::ptr_width-1:0] wr_ptr;
	logic [macc_pkg::ptr_width-1:0] rd_ptr;

	// Write side
	always_ff @(posedge clk) begin
		if (push) begin
			op_mem[wr_ptr] <= push_op;
			a_mem[wr_ptr] <= push_a;
			b_mem[wr_ptr] <= push_b;
		end
	end

	// Pointer and occupancy tracking
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head entry always visible
	assign pop_op = op_mem[rd_ptr];
	assign pop_a = a_mem[rd_ptr];
	assign pop_b = b_mem[rd_ptr];

	assign empty = (count == '0);
	assign full = (count == macc_pkg::count_width'(macc_pkg::fifo_depth));

endmodule

// File: src/apb_macc_regs.sv
// APB slave with no wait states; pslverr on unmapped addresses or a push into a full FIFO, no strobes
`timescale 1ns/10ps

module apb_macc_regs (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   psel,
	input  logic                                   penable,
	input  logic                                   pwrite,
	input  logic [macc_pkg::addr_width-1:0]        paddr,
	input  logic [macc_pkg::data_width-1:0]        pwdata,
	output logic [macc_pkg::data_width-1:0]        prdata,
	output logic                                   pready,
	output logic                                   pslverr,
	output logic                                   push,
	output macc_pkg::macc_op_e                     push_op,
	output logic signed [macc_pkg::sample_width-1:0] push_a,
	output logic signed [macc_pkg::sample_width-1:0] push_b,
	output logic                                   run,
	input  logic                                   full,
	input  logic                                   empty,
	input  logic [macc_pkg::count_width-1:0]       count,
	input  logic signed [macc_pkg::acc_width-1:0]  acc,
	input  logic                                   overflow,
	input  logic                                   pipe_busy
);

	// Access phase qualifiers
	logic access;
	logic wr_access;
	logic rd_access;

	// One-hot address decode
	logic sel_operand;
	logic sel_load;
	logic sel_ctrl;
	logic sel_status;
	logic sel_acc_lo;
	logic sel_acc_hi;
	logic mapped;

	logic need_push;
	logic reject;
	logic [macc_pkg::data_width-1:0] status_word;

	// No wait states ever
	assign pready = 1'b1;

	// Writes and reads act only in the access phase
	assign access = psel & penable;
	assign wr_access = access & pwrite;
	assign rd_access = access & ~pwrite;

	assign sel_operand = (paddr == macc_pkg::addr_operand);
	assign sel_load = (paddr == macc_pkg::addr_load);
	assign sel_ctrl = (paddr == macc_pkg::addr_ctrl);
	assign sel_status = (paddr == macc_pkg::addr_status);
	assign sel_acc_lo = (paddr == macc_pkg::addr_acc_lo);
	assign sel_acc_hi = (paddr == macc_pkg::addr_acc_hi);
	assign mapped = sel_operand | sel_load | sel_ctrl | sel_status | sel_acc_lo | sel_acc_hi;

	// Operand and load writes always push, CTRL only when the clear bit is set
	assign need_push = wr_access & (sel_operand | sel_load | (sel_ctrl & pwdata[1]));

	// Failing writes change nothing, run included
	assign reject = access & (~mapped | (need_push & full));
	assign pslverr = reject;

	// FIFO sees a push only when there is room
	assign push = need_push & ~full;

	always_comb begin
		if (sel_load) begin
			push_op = macc_pkg::op_load;
		end else if (sel_ctrl) begin
			push_op = macc_pkg::op_clear;
		end else begin
			push_op = macc_pkg::op_mac;
		end
	end

	// Operand layout: a low half, b high half
	// ignored by clear commands
	assign push_a = pwdata[macc_pkg::sample_width-1:0];
	assign push_b = pwdata[2*macc_pkg::sample_width-1:macc_pkg::sample_width];

	// Run bit
	always_ff @(posedge clk) begin
		if (rst) begin
			run <= 1'b0;
		end else if (wr_access && sel_ctrl && !reject) begin
			run <= pwdata[0];
		end
	end

	// Status word assembly
	always_comb begin
		status_word = '0;
		status_word[macc_pkg::count_width-1:0] = count;
		status_word[macc_pkg::status_empty_bit] = empty;
		status_word[macc_pkg::status_full_bit] = full;
		// Busy until the FIFO drains and the last entry has landed
		status_word[macc_pkg::status_busy_bit] = ~empty | pipe_busy;
		status_word[macc_pkg::status_ovf_bit] = overflow;
	end

	// Read mux, zero outside a read access
	always_comb begin
		prdata = '0;
		if (rd_access) begin
			if (sel_ctrl) begin
				prdata[0] = run;
			end else if (sel_status) begin
				prdata = status_word;
			end else if (sel_acc_lo) begin
				prdata = acc[macc_pkg::data_width-1:0];
			end else if (sel_acc_hi) begin
				// Top byte sign extended to a full word
				prdata = {{(2 * macc_pkg::data_width - macc_pkg::acc_width){acc[macc_pkg::acc_width-1]}},
					acc[macc_pkg::acc_width-1:macc_pkg::data_width]};
			end
		end
	end

endmodule

// File: src/macc_pkg.sv
// Widths are fixed here; fifo_depth must stay a power of two so the FIFO pointers wrap on their own
package macc_pkg;

	// Operand and accumulator widths
	localparam int sample_width = 16;
	localparam int prod_width = 2 * sample_width;
	localparam int acc_width = 40;

	// Operand FIFO sizing
	localparam int fifo_depth = 8;
	localparam int ptr_width = 3;
	// Count has to hold 0 through fifo_depth inclusive
	localparam int count_width = 4;

	// APB bus widths
	localparam int addr_width = 8;
	localparam int data_width = 32;

	// Register map, byte addresses
	// Write pushes op_mac, a in [15:0], b in [31:16]
	localparam logic [addr_width-1:0] addr_operand = 8'h00;
	// Write pushes op_load, same operand layout
	localparam logic [addr_width-1:0] addr_load = 8'h04;
	// Bit 0 run, bit 1 requests a clear push
	localparam logic [addr_width-1:0] addr_ctrl = 8'h08;
	// Read only FIFO and pipeline status
	localparam logic [addr_width-1:0] addr_status = 8'h0C;
	// Accumulator low word
	localparam logic [addr_width-1:0] addr_acc_lo = 8'h10;
	// Accumulator top byte, sign extended
	localparam logic [addr_width-1:0] addr_acc_hi = 8'h14;

	// Status word bit positions
	localparam int status_empty_bit = 4;
	localparam int status_full_bit = 5;
	localparam int status_busy_bit = 6;
	localparam int status_ovf_bit = 7;

	// Saturation limits of the signed accumulator
	localparam logic signed [acc_width-1:0] acc_max = {1'b0, {(acc_width - 1){1'b1}}};
	localparam logic signed [acc_width-1:0] acc_min = {1'b1, {(acc_width - 1){1'b0}}};

	// Command opcodes carried through the FIFO and the pipeline
	typedef enum logic [1:0] {
		// Accumulator plus product
		op_mac = 2'd0,
		// Accumulator takes the product
		op_load = 2'd1,
		// Accumulator and overflow go to zero
		op_clear = 2'd2
	} macc_op_e;

endpackage
